//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_attention_head
FILELIST  := attention_head.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- attention_head.f
src/attn_fmt_pkg.sv
src/attn_ctrl_pkg.sv
src/kv_store.sv
src/score_unit.sv
src/weighted_sum.sv
src/attention_head.sv
sim/attn_checker.sv
sim/tb_attention_head.sv

//--- sim/attn_checker.sv
`timescale 1ns/1ps

module attn_checker
  import attn_fmt_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  kv_entry_t kv_data,
  input  logic      kv_valid,
  input  logic      kv_ready,
  input  logic      kv_clear,
  input  row_t      query,
  input  logic      query_valid,
  input  logic      query_ready,
  input  row_t      out,
  input  logic      out_valid,
  input  logic      out_ready,
  input  row_t      table_exp,
  input  logic      table_use,
  output int        err_cnt,
  output int        pending
);

  kv_entry_t store [SEQ_LEN];
  int        fill;
  row_t      exp_q [$];
  row_t      exp_row;
  row_t      held;
  logic      stalled;
  // DUT outputs only move on rising edges
  logic      s_kv_ready;
  logic      s_query_ready;
  logic      s_out_valid;
  row_t      s_out;

  // Base-2 weights and a weighted mean truncated toward zero
  function automatic row_t attend(input row_t q);
    longint s [SEQ_LEN];
    longint num [HEAD_DIM];
    longint mx;
    longint d;
    longint w;
    longint den;
    row_t   r;
    mx  = 0;
    den = 0;
    for (int j = 0; j < SEQ_LEN; j++) begin
      s[j] = 0;
      for (int i = 0; i < HEAD_DIM; i++) begin
        s[j] += longint'(q.e[i]) * longint'(store[j].key.e[i]);
      end
      if (j == 0 || s[j] > mx) begin
        mx = s[j];
      end
    end
    for (int i = 0; i < HEAD_DIM; i++) begin
      num[i] = 0;
    end
    for (int j = 0; j < SEQ_LEN; j++) begin
      d   = mx - s[j];
      w   = (d >= MAX_SHIFT) ? 0 : (longint'(256) >> d);
      den += w;
      for (int i = 0; i < HEAD_DIM; i++) begin
        num[i] += w * longint'(store[j].val.e[i]);
      end
    end
    for (int i = 0; i < HEAD_DIM; i++) begin
      r.e[i] = elem_t'(num[i] / den);
    end
    return r;
  endfunction

  always @(negedge clk) begin
    s_kv_ready    <= kv_ready;
    s_query_ready <= query_ready;
    s_out_valid   <= out_valid;
    s_out         <= out;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill    = 0;
      stalled = 1'b0;
      err_cnt = 0;
      exp_q.delete();
    end else begin
      if (s_kv_ready !== (fill < SEQ_LEN)) begin
        $display("** Error at %0t: kv_ready is %b with %0d rows stored",
                 $time, s_kv_ready, fill);
        err_cnt++;
      end
      if (s_query_ready && fill < SEQ_LEN) begin
        $display("** Error at %0t: query_ready is high with only %0d rows stored",
                 $time, fill);
        err_cnt++;
      end
      if (s_out_valid && exp_q.size() == 0) begin
        $display("** Error at %0t: out_valid is high with no query outstanding",
                 $time);
        err_cnt++;
      end
      if (stalled && s_out !== held) begin
        $display("** Error at %0t: out changed under stall, held %h, now %h", $time, held, s_out);
        err_cnt++;
      end
      if (kv_clear) begin
        fill = 0;
      end else if (kv_valid && s_kv_ready && fill < SEQ_LEN) begin
        store[fill] = kv_data;
        fill++;
      end
      if (query_valid && s_query_ready) begin
        exp_q.push_back(table_use ? table_exp : attend(query));
      end
      if (s_out_valid && out_ready && exp_q.size() != 0) begin
        exp_row = exp_q.pop_front();
        for (int i = 0; i < HEAD_DIM; i++) begin
          if (s_out.e[i] !== exp_row.e[i]) begin
            $display("** Error at %0t: out.e[%0d] expected %0d, got %0d",
                     $time, i, exp_row.e[i], s_out.e[i]);
            err_cnt++;
          end
        end
      end
      stalled = s_out_valid && !out_ready;
      held    = s_out;
    end
    pending = exp_q.size();
  end

endmodule

//--- sim/tb_attention_head.sv
`timescale 1ns/1ps

module tb_attention_head
  import attn_fmt_pkg::*;
();

  localparam int NUM_TESTS = 5;
  localparam int SEED      = 32'h5c85;

  typedef struct packed {
    logic       clear;
    logic       load;
    row_t       query;
    row_t       expected;
    logic [7:0] n_rand;
    logic       stall;
  } test_t;

  logic      clk;
  logic      arst_n;
  kv_entry_t kv_data;
  logic      kv_valid;
  logic      kv_ready;
  logic      kv_clear;
  row_t      query;
  logic      query_valid;
  logic      query_ready;
  row_t      out;
  logic      out_valid;
  logic      out_ready;
  row_t      table_exp;
  logic      table_use;
  logic      stall_mode;
  logic      stall_bit;
  int        err_cnt;
  int        pending;
  int        cycles = 0;
  int        cycle_limit;
  int        passed;
  int        failed;

  test_t     tests [NUM_TESTS];
  kv_entry_t kv_tab [NUM_TESTS][SEQ_LEN];

  attention_head u_dut (.*);
  attn_checker   u_chk (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  assign out_ready = !stall_mode || stall_bit;

  always @(negedge clk) begin
    stall_bit <= ($urandom_range(2) != 0);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles: the DUT hung", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic row_t make_row(input int a, input int b, input int c, input int d);
    row_t r;
    r.e[0] = elem_t'(a);
    r.e[1] = elem_t'(b);
    r.e[2] = elem_t'(c);
    r.e[3] = elem_t'(d);
    return r;
  endfunction

  function automatic void set_kv(input int t, input int j, input row_t k, input row_t v);
    kv_tab[t][j].key = k;
    kv_tab[t][j].val = v;
  endfunction

  function automatic void add_test(input int t, input logic clr, input logic ld, input row_t q,
                                   input row_t exp, input int n_rand, input logic stall);
    tests[t] = '{clr, ld, q, exp, 8'(n_rand), stall};
  endfunction

  function automatic void fill_table();
    // clear, load, directed query, its expected row, random queries, stalls
    add_test(0, 0, 1, make_row(1, 2, 3, 4), make_row(2, -4, 1, -2), 4, 0);
    add_test(1, 1, 1, make_row(1, 0, 0, 0), make_row(-128, 127, -1, 55), 2, 0);
    add_test(2, 1, 1, make_row(1, 0, 0, 0), make_row(9, 2, 0, 3), 2, 0);
    add_test(3, 0, 0, make_row(0, 0, 0, 0), make_row(22, -1, 0, -30), 16, 1);
    add_test(4, 1, 1, make_row(0, 0, 0, 0), make_row(-1, 1, 0, -32), 6, 0);
    // Equal scores
    set_kv(0, 0, make_row(0, 0, 0, 0), make_row(4, -8, 1, 0));
    set_kv(0, 1, make_row(0, 0, 0, 0), make_row(8, -4, 2, -3));
    set_kv(0, 2, make_row(0, 0, 0, 0), make_row(-2, 0, 3, -6));
    set_kv(0, 3, make_row(0, 0, 0, 0), make_row(1, -5, 0, -2));
    // Key 0 leads by 9 or more
    set_kv(1, 0, make_row(10, 0, 0, 0), make_row(-128, 127, -1, 55));
    set_kv(1, 1, make_row(0, 0, 0, 0), make_row(100, 100, 100, 100));
    set_kv(1, 2, make_row(1, 0, 0, 0), make_row(-50, 3, 9, -7));
    set_kv(1, 3, make_row(-1, 0, 0, 0), make_row(1, 2, 3, 4));
    // Gaps 0, 1, 3 and 8
    set_kv(2, 0, make_row(5, 0, 0, 0), make_row(10, -10, 0, 7));
    set_kv(2, 1, make_row(4, 0, 0, 0), make_row(20, 5, -1, 0));
    set_kv(2, 2, make_row(2, 0, 0, 0), make_row(-40, 100, 3, 0));
    set_kv(2, 3, make_row(-3, 0, 0, 0), make_row(100, -100, 0, -128));
    set_kv(4, 0, make_row(3, -1, 0, 2), make_row(-1, -1, -1, -1));
    set_kv(4, 1, make_row(-2, 5, 1, 0), make_row(-2, 2, 0, 0));
    set_kv(4, 2, make_row(0, 0, 4, -3), make_row(0, 0, 0, 0));
    set_kv(4, 3, make_row(1, 1, 1, 1), make_row(-1, 3, 1, -128));
  endfunction

  // Called and returning on a falling edge
  task automatic send_kv(input kv_entry_t e);
    kv_data  = e;
    kv_valid = 1'b1;
    while (!kv_ready) @(negedge clk);
    @(negedge clk);
    kv_valid = 1'b0;
  endtask

  task automatic send_query(input row_t q, input logic use_tab, input row_t exp);
    query       = q;
    table_use   = use_tab;
    table_exp   = exp;
    query_valid = 1'b1;
    while (!query_ready) @(negedge clk);
    @(negedge clk);
    query_valid = 1'b0;
    table_use   = 1'b0;
  endtask

  task automatic run_test(input int t);
    int   err_before;
    row_t r;
    err_before = err_cnt;
    if (tests[t].clear) begin
      kv_clear = 1'b1;
      @(negedge clk);
      kv_clear = 1'b0;
    end
    if (tests[t].load) begin
      for (int j = 0; j < SEQ_LEN; j++) begin
        send_kv(kv_tab[t][j]);
      end
    end
    stall_mode = tests[t].stall;
    send_query(tests[t].query, 1'b1, tests[t].expected);
    for (int n = 0; n < int'(tests[t].n_rand); n++) begin
      for (int i = 0; i < HEAD_DIM; i++) begin
        r.e[i] = elem_t'($urandom);
      end
      send_query(r, 1'b0, '0);
    end
    while (pending != 0) @(negedge clk);
    stall_mode = 1'b0;
    if (err_cnt == err_before) begin
      passed++;
    end else begin
      failed++;
    end
    $display("test %0d: %0d queries, %0d mismatches", t, 1 + int'(tests[t].n_rand),
             err_cnt - err_before);
  endtask

  initial begin
    int total;
    void'($urandom(SEED));
    arst_n      = 1'b0;
    kv_data     = '0;
    kv_valid    = 1'b0;
    kv_clear    = 1'b0;
    query       = '0;
    query_valid = 1'b0;
    table_exp   = '0;
    table_use   = 1'b0;
    stall_mode  = 1'b0;
    passed      = 0;
    failed      = 0;
    total       = 0;
    fill_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += 1 + int'(tests[t].n_rand);
    end
    cycle_limit = total * 200 + 1000;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests passed, %0d failed, %0d errors", passed, failed, err_cnt);
    if (failed == 0 && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- src/attention_head.sv
`timescale 1ns/1ps

module attention_head
  import attn_fmt_pkg::*;
  import attn_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,

  input  kv_entry_t kv_data,
  input  logic      kv_valid,
  output logic      kv_ready,
  input  logic      kv_clear,

  input  row_t      query,
  input  logic      query_valid,
  output logic      query_ready,

  output row_t      out,
  output logic      out_valid,
  input  logic      out_ready
);

  logic             kv_full;
  logic [IDX_W-1:0] key_idx;
  row_t             key_row;
  logic [IDX_W-1:0] val_idx;
  row_t             val_row;
  score_vec_t       score_vec;
  logic             scores_valid;
  logic             scores_ready;

  kv_store u_store (
    .clk      (clk),
    .arst_n   (arst_n),
    .kv_data  (kv_data),
    .kv_valid (kv_valid),
    .kv_ready (kv_ready),
    .kv_clear (kv_clear),
    .kv_full  (kv_full),
    .key_idx  (key_idx),
    .key_row  (key_row),
    .val_idx  (val_idx),
    .val_row  (val_row)
  );

  score_unit u_score (
    .clk          (clk),
    .arst_n       (arst_n),
    .query        (query),
    .query_valid  (query_valid),
    .query_ready  (query_ready),
    .kv_full      (kv_full),
    .key_idx      (key_idx),
    .key_row      (key_row),
    .score_vec    (score_vec),
    .scores_valid (scores_valid),
    .scores_ready (scores_ready)
  );

  weighted_sum u_wsum (
    .clk          (clk),
    .arst_n       (arst_n),
    .score_vec    (score_vec),
    .scores_valid (scores_valid),
    .scores_ready (scores_ready),
    .val_idx      (val_idx),
    .val_row      (val_row),
    .out          (out),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

  // Store may only be emptied once both units have drained
  a_clear_when_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    kv_clear |-> (!out_valid && scores_ready && u_score.state == SC_IDLE)
  );

endmodule

//--- src/attn_ctrl_pkg.sv
package attn_ctrl_pkg;

  // Score unit FSM
  typedef enum logic [1:0] {
    SC_IDLE,
    SC_DOT,
    SC_EMIT
  } score_state_e;

  // Weighted-sum unit FSM
  typedef enum logic [1:0] {
    WS_IDLE,
    WS_ACCUM,
    WS_DIVIDE,
    WS_OUTPUT
  } wsum_state_e;

endpackage

//--- src/attn_fmt_pkg.sv
package attn_fmt_pkg;

  // Sequence and row sizes
  localparam int SEQ_LEN  = 4;
  localparam int HEAD_DIM = 4;

  localparam int IDX_W      = $clog2(SEQ_LEN);
  localparam int ELEM_IDX_W = $clog2(HEAD_DIM);

  // Arithmetic widths
  localparam int ELEM_W    = 8;
  localparam int SCORE_W   = 18;
  localparam int WEIGHT_W  = 9;
  localparam int NUM_W     = 19;
  localparam int DEN_W     = 11;
  localparam int BIT_CNT_W = $clog2(NUM_W);

  // Weight of the maximum row; one shift step per unit of score distance
  localparam int WEIGHT_ONE = 1 << (WEIGHT_W - 1);
  localparam int MAX_SHIFT  = 9;

  typedef logic signed [ELEM_W-1:0]  elem_t;
  typedef logic signed [SCORE_W-1:0] score_t;

  // Element 0 sits in the low bits
  typedef struct packed {
    elem_t [HEAD_DIM-1:0] e;
  } row_t;

  typedef struct packed {
    row_t key;
    row_t val;
  } kv_entry_t;

  typedef struct packed {
    score_t                max_score;
    score_t [SEQ_LEN-1:0]  score;
  } score_vec_t;

endpackage

//--- src/kv_store.sv
`timescale 1ns/1ps

module kv_store
  import attn_fmt_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,

  input  kv_entry_t        kv_data,
  input  logic             kv_valid,
  output logic             kv_ready,
  input  logic             kv_clear,

  output logic             kv_full,

  input  logic [IDX_W-1:0] key_idx,
  output row_t             key_row,
  input  logic [IDX_W-1:0] val_idx,
  output row_t             val_row
);

  row_t           keys [SEQ_LEN];
  row_t           vals [SEQ_LEN];
  logic [IDX_W:0] fill;
  logic           wr_en;

  assign kv_full  = (fill == (IDX_W + 1)'(SEQ_LEN));
  assign kv_ready = !kv_full;
  assign wr_en    = kv_valid && kv_ready;

  // Fill level
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill <= '0;
    end else if (kv_clear) begin
      fill <= '0;
    end else if (wr_en) begin
      fill <= fill + 1'b1;
    end
  end

  // Row storage at the next free slot
  always_ff @(posedge clk) begin
    if (wr_en) begin
      keys[fill[IDX_W-1:0]] <= kv_data.key;
      vals[fill[IDX_W-1:0]] <= kv_data.val;
    end
  end

  assign key_row = keys[key_idx];
  assign val_row = vals[val_idx];

  // A clear racing a write would drop or misplace a row
  a_no_clear_on_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(kv_clear && kv_valid && kv_ready)
  );

endmodule

//--- src/score_unit.sv
`timescale 1ns/1ps

module score_unit
  import attn_fmt_pkg::*;
  import attn_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,

  input  row_t             query,
  input  logic             query_valid,
  output logic             query_ready,

  input  logic             kv_full,
  output logic [IDX_W-1:0] key_idx,
  input  row_t             key_row,

  output score_vec_t       score_vec,
  output logic             scores_valid,
  input  logic             scores_ready
);

  score_state_e     state;
  row_t             q_reg;
  score_t           dot;
  logic [IDX_W-1:0] idx;

  assign query_ready  = (state == SC_IDLE) && kv_full;
  assign scores_valid = (state == SC_EMIT);
  assign key_idx      = idx;

  // One key per cycle
  always_comb begin
    dot = '0;
    for (int i = 0; i < HEAD_DIM; i++) begin
      dot = dot + score_t'(q_reg.e[i]) * score_t'(key_row.e[i]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= SC_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        SC_IDLE: begin
          if (query_valid && query_ready) begin
            idx   <= '0;
            state <= SC_DOT;
          end
        end
        SC_DOT: begin
          if (idx == IDX_W'(SEQ_LEN - 1)) begin
            idx   <= '0;
            state <= SC_EMIT;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        SC_EMIT: begin
          // Held here while the consumer is still busy
          if (scores_ready) begin
            state <= SC_IDLE;
          end
        end
        default: state <= SC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (query_valid && query_ready) begin
      q_reg <= query;
    end
    if (state == SC_DOT) begin
      score_vec.score[idx] <= dot;
      if (idx == '0 || dot > score_vec.max_score) begin
        score_vec.max_score <= dot;
      end
    end
  end

  // Keys must not change underneath an active query
  a_full_during_dot: assert property (
    @(posedge clk) disable iff (!arst_n)
    (query_valid && query_ready) |-> kv_full [* SEQ_LEN + 1]
  );

  a_scores_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (scores_valid && !scores_ready) |=> (scores_valid && $stable(score_vec))
  );

endmodule

//--- src/weighted_sum.sv
`timescale 1ns/1ps

module weighted_sum
  import attn_fmt_pkg::*;
  import attn_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,

  input  score_vec_t       score_vec,
  input  logic             scores_valid,
  output logic             scores_ready,

  output logic [IDX_W-1:0] val_idx,
  input  row_t             val_row,

  output row_t             out,
  output logic             out_valid,
  input  logic             out_ready
);

  wsum_state_e               state;
  logic [IDX_W-1:0]          acc_idx;
  logic [ELEM_IDX_W-1:0]     elem;
  logic [BIT_CNT_W-1:0]      bit_cnt;

  score_vec_t                sv_reg;
  logic signed [NUM_W-1:0]   num [HEAD_DIM];
  logic [DEN_W-1:0]          den;
  logic [DEN_W-1:0]          rem;
  logic [NUM_W-1:0]          quo;
  row_t                      out_reg;

  logic [SCORE_W-1:0]        diff;
  logic [WEIGHT_W-1:0]       weight;
  logic signed [NUM_W-1:0]   wgt_s;

  logic signed [NUM_W-1:0]   num_sel;
  logic [NUM_W-1:0]          div_src;
  logic [DEN_W-1:0]          rem_cur;
  logic [DEN_W:0]            rem_sh;
  logic                      q_bit;
  logic [DEN_W-1:0]          rem_nxt;
  logic [NUM_W-1:0]          quo_nxt;
  logic signed [NUM_W-1:0]   res;

  assign scores_ready = (state == WS_IDLE);
  assign out_valid    = (state == WS_OUTPUT);
  assign out          = out_reg;
  assign val_idx      = acc_idx;

  // Power-of-two weight from distance below the maximum
  assign diff   = sv_reg.max_score - sv_reg.score[acc_idx];
  assign weight = (diff >= SCORE_W'(MAX_SHIFT)) ? '0 : WEIGHT_W'(WEIGHT_ONE >> diff);
  assign wgt_s  = NUM_W'(weight);

  // Restoring divide on magnitudes with one quotient bit per cycle
  always_comb begin
    num_sel = num[elem];
    if (bit_cnt == '0) begin
      div_src = num_sel[NUM_W-1] ? NUM_W'(-num_sel) : NUM_W'(num_sel);
      rem_cur = '0;
    end else begin
      div_src = quo;
      rem_cur = rem;
    end
    rem_sh  = {rem_cur, div_src[NUM_W-1]};
    q_bit   = (rem_sh >= {1'b0, den});
    rem_nxt = q_bit ? DEN_W'(rem_sh - {1'b0, den}) : rem_sh[DEN_W-1:0];
    quo_nxt = {div_src[NUM_W-2:0], q_bit};
    res     = num_sel[NUM_W-1] ? -signed'(quo_nxt) : signed'(quo_nxt);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= WS_IDLE;
      acc_idx <= '0;
      elem    <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        WS_IDLE: begin
          if (scores_valid) begin
            acc_idx <= '0;
            state   <= WS_ACCUM;
          end
        end
        WS_ACCUM: begin
          if (acc_idx == IDX_W'(SEQ_LEN - 1)) begin
            acc_idx <= '0;
            elem    <= '0;
            bit_cnt <= '0;
            state   <= WS_DIVIDE;
          end else begin
            acc_idx <= acc_idx + 1'b1;
          end
        end
        WS_DIVIDE: begin
          if (bit_cnt == BIT_CNT_W'(NUM_W - 1)) begin
            bit_cnt <= '0;
            if (elem == ELEM_IDX_W'(HEAD_DIM - 1)) begin
              state <= WS_OUTPUT;
            end else begin
              elem <= elem + 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        WS_OUTPUT: begin
          if (out_ready) begin
            state <= WS_IDLE;
          end
        end
        default: state <= WS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (scores_valid && scores_ready) begin
      sv_reg <= score_vec;
      den    <= '0;
      for (int i = 0; i < HEAD_DIM; i++) begin
        num[i] <= '0;
      end
    end
    if (state == WS_ACCUM) begin
      den <= den + DEN_W'(weight);
      for (int i = 0; i < HEAD_DIM; i++) begin
        num[i] <= num[i] + wgt_s * val_row.e[i];
      end
    end
    if (state == WS_DIVIDE) begin
      rem <= rem_nxt;
      quo <= quo_nxt;
      if (bit_cnt == BIT_CNT_W'(NUM_W - 1)) begin
        out_reg.e[elem] <= elem_t'(res);
      end
    end
  end

  // The row holding the maximum always contributes a full weight
  a_den_nonzero: assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == WS_ACCUM && acc_idx == IDX_W'(SEQ_LEN - 1)) |=> (den >= DEN_W'(WEIGHT_ONE))
  );

endmodule
